// ==== csr_pkg.sv ====
package csr_pkg;

    // Basic data widths
    typedef logic [31:0] word_t;      // One machine word
    typedef logic [63:0] dword_t;     // Full counter value
    typedef logic [11:0] csr_addr_t;  // CSR address space

    // Machine information registers, read only
    localparam csr_addr_t CSR_MVENDORID     = 12'hF11;
    localparam csr_addr_t CSR_MARCHID       = 12'hF12;
    localparam csr_addr_t CSR_MIMPID        = 12'hF13;
    localparam csr_addr_t CSR_MHARTID       = 12'hF14;

    // Machine trap setup
    localparam csr_addr_t CSR_MSTATUS       = 12'h300;
    localparam csr_addr_t CSR_MISA          = 12'h301;  // Read only here
    localparam csr_addr_t CSR_MTVEC         = 12'h305;
    localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320;

    // Machine trap handling
    localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
    localparam csr_addr_t CSR_MEPC          = 12'h341;
    localparam csr_addr_t CSR_MCAUSE        = 12'h342;
    localparam csr_addr_t CSR_MTVAL         = 12'h343;

    // Machine counters, low and high halves
    localparam csr_addr_t CSR_MCYCLE        = 12'hB00;
    localparam csr_addr_t CSR_MINSTRET      = 12'hB02;
    localparam csr_addr_t CSR_MCYCLEH       = 12'hB80;
    localparam csr_addr_t CSR_MINSTRETH     = 12'hB82;

    // User mode aliases
    localparam csr_addr_t CSR_CYCLE         = 12'hC00;
    localparam csr_addr_t CSR_TIME          = 12'hC01;  // No machine alias
    localparam csr_addr_t CSR_INSTRET       = 12'hC02;
    localparam csr_addr_t CSR_CYCLEH        = 12'hC80;
    localparam csr_addr_t CSR_TIMEH         = 12'hC81;
    localparam csr_addr_t CSR_INSTRETH      = 12'hC82;

    // mstatus, only the two interrupt enable bits are live
    typedef struct packed {
        logic [23:0] reserved_8;
        logic        mpie;        // Bit 7, prior mie
        logic [2:0]  reserved_4;
        logic        mie;         // Bit 3, machine interrupt enable
        logic [2:0]  reserved_0;
    } mstatus_t;

    // Trap vector, base is word aligned
    typedef struct packed {
        logic [29:0] base;
        logic [1:0]  mode;        // 0 direct, 1 vectored
    } mtvec_t;

    // Trap cause, interrupt flag on top
    typedef struct packed {
        logic        is_interrupt;
        logic [30:0] exception_code;
    } mcause_t;

    // mcountinhibit bit positions
    localparam int MCOUNTINHIBIT_CY = 0;  // Stops mcycle
    localparam int MCOUNTINHIBIT_IR = 2;  // Stops minstret

    // Identity constants
    localparam word_t MISA_VALUE   = 32'h4000_0100;  // MXL=1, I extension only
    localparam word_t MIMPID_VALUE = 32'h0000_0001;  // Version 1

    // Reset values, one per register type
    localparam word_t    WORD_RESET    = '0;
    localparam dword_t   DWORD_RESET   = '0;
    localparam mstatus_t MSTATUS_RESET = '0;  // Interrupts off after reset
    localparam mtvec_t   MTVEC_RESET   = '0;
    localparam mcause_t  MCAUSE_RESET  = '0;

endpackage

// ==== csr_counter.sv ====
`timescale 1ns/1ps

module csr_counter (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             count_i,      // Advance by one this cycle
    input  logic             load_lo_i,    // Write to low half
    input  logic             load_hi_i,    // Write to high half
    input  csr_pkg::word_t   load_data_i,  // Value for the written half
    output csr_pkg::dword_t  value_o
);

    csr_pkg::dword_t value_r;    // Current count
    csr_pkg::dword_t value_inc;  // Count after this cycle's step
    csr_pkg::word_t  load_inc;   // Written half after this cycle's step
    csr_pkg::dword_t value_nxt;

    // The step is applied in the write cycle too
    // A written half therefore reads back as D+1 when counting
    always_comb begin
        value_inc = value_r + {63'b0, count_i};
        load_inc  = load_data_i + {31'b0, count_i};
        value_nxt = value_inc;                 // Other half keeps counting

        if (load_lo_i) begin
            value_nxt[31:0] = load_inc;        // Low half replaced
        end

        if (load_hi_i) begin
            value_nxt[63:32] = load_inc;       // High half replaced
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            value_r <= csr_pkg::DWORD_RESET;
        end else begin
            value_r <= value_nxt;
        end
    end

    assign value_o = value_r;

endmodule

// ==== csr_counter_bank.sv ====
`timescale 1ns/1ps

module csr_counter_bank (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                retired_i,           // One instruction retired
    input  logic                csr_write_enable_i,
    input  csr_pkg::csr_addr_t  csr_write_addr_i,
    input  csr_pkg::word_t      csr_write_data_i,
    output csr_pkg::dword_t     mcycle_o,
    output csr_pkg::dword_t     minstret_o,
    output csr_pkg::dword_t     time_o,
    output csr_pkg::word_t      mcountinhibit_o
);

    csr_pkg::word_t mcountinhibit_r;

    // Per-counter count enables
    logic cycle_count;
    logic instret_count;

    // Half-word write strobes
    logic cycle_lo_we,   cycle_hi_we;
    logic instret_lo_we, instret_hi_we;
    logic time_lo_we,    time_hi_we;
    logic inhibit_we;

    // Machine and user addresses both write the same counter
    always_comb begin
        cycle_lo_we   = 1'b0;
        cycle_hi_we   = 1'b0;
        instret_lo_we = 1'b0;
        instret_hi_we = 1'b0;
        time_lo_we    = 1'b0;
        time_hi_we    = 1'b0;
        inhibit_we    = 1'b0;

        if (csr_write_enable_i) begin
            case (csr_write_addr_i)
                csr_pkg::CSR_MCYCLE,    csr_pkg::CSR_CYCLE:    cycle_lo_we   = 1'b1;
                csr_pkg::CSR_MCYCLEH,   csr_pkg::CSR_CYCLEH:   cycle_hi_we   = 1'b1;
                csr_pkg::CSR_MINSTRET,  csr_pkg::CSR_INSTRET:  instret_lo_we = 1'b1;
                csr_pkg::CSR_MINSTRETH, csr_pkg::CSR_INSTRETH: instret_hi_we = 1'b1;
                csr_pkg::CSR_TIME:          time_lo_we = 1'b1;
                csr_pkg::CSR_TIMEH:         time_hi_we = 1'b1;
                csr_pkg::CSR_MCOUNTINHIBIT: inhibit_we = 1'b1;
                default: ;                                     // Not a counter address
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mcountinhibit_r <= csr_pkg::WORD_RESET;
        end else if (inhibit_we) begin
            mcountinhibit_r <= csr_write_data_i;
        end
    end

    assign cycle_count   = ~mcountinhibit_r[csr_pkg::MCOUNTINHIBIT_CY];
    assign instret_count = retired_i & ~mcountinhibit_r[csr_pkg::MCOUNTINHIBIT_IR];

    csr_counter u_mcycle (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .count_i     (cycle_count),
        .load_lo_i   (cycle_lo_we),
        .load_hi_i   (cycle_hi_we),
        .load_data_i (csr_write_data_i),
        .value_o     (mcycle_o)
    );

    csr_counter u_minstret (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .count_i     (instret_count),
        .load_lo_i   (instret_lo_we),
        .load_hi_i   (instret_hi_we),
        .load_data_i (csr_write_data_i),
        .value_o     (minstret_o)
    );

    // Real time runs every cycle, inhibit has no effect on it
    csr_counter u_time (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .count_i     (1'b1),
        .load_lo_i   (time_lo_we),
        .load_hi_i   (time_hi_we),
        .load_data_i (csr_write_data_i),
        .value_o     (time_o)
    );

    assign mcountinhibit_o = mcountinhibit_r;

endmodule

// ==== csr_trap_regs.sv ====
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                mtrap_i,             // Trap taken this cycle
    input  logic                mret_i,              // mret executed this cycle
    input  logic                csr_write_enable_i,
    input  csr_pkg::csr_addr_t  csr_write_addr_i,
    input  csr_pkg::word_t      csr_write_data_i,
    output csr_pkg::mstatus_t   mstatus_o,
    output csr_pkg::mtvec_t     mtvec_o,
    output csr_pkg::word_t      mscratch_o,
    output csr_pkg::word_t      mepc_o,
    output csr_pkg::word_t      mtval_o,
    output csr_pkg::mcause_t    mcause_o
);

    csr_pkg::mtvec_t   mtvec_r;
    csr_pkg::word_t    mscratch_r;
    csr_pkg::word_t    mepc_r;
    csr_pkg::mcause_t  mcause_r;
    csr_pkg::word_t    mtval_r;

    // Live mstatus bits
    logic mie_r,  mie_nxt;
    logic mpie_r, mpie_nxt;

    csr_pkg::mstatus_t mstatus_wr;  // Write data viewed as mstatus
    logic              mstatus_we;

    assign mstatus_wr = csr_pkg::mstatus_t'(csr_write_data_i);
    assign mstatus_we = csr_write_enable_i && (csr_write_addr_i == csr_pkg::CSR_MSTATUS);

    // Interrupt enable stack, software write wins over trap and return
    always_comb begin
        mie_nxt  = mie_r;
        mpie_nxt = mpie_r;

        if (mstatus_we) begin
            mie_nxt  = mstatus_wr.mie;
            mpie_nxt = mstatus_wr.mpie;
        end else if (mtrap_i) begin
            mie_nxt  = 1'b0;           // Interrupts off in handler
            mpie_nxt = mie_r;          // Save old enable
        end else if (mret_i) begin
            mie_nxt  = mpie_r;         // Restore saved enable
            mpie_nxt = 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mie_r  <= csr_pkg::MSTATUS_RESET.mie;
            mpie_r <= csr_pkg::MSTATUS_RESET.mpie;
        end else begin
            mie_r  <= mie_nxt;
            mpie_r <= mpie_nxt;
        end
    end

    // Plain read/write registers
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            mtvec_r    <= csr_pkg::MTVEC_RESET;
            mscratch_r <= csr_pkg::WORD_RESET;
            mepc_r     <= csr_pkg::WORD_RESET;
            mcause_r   <= csr_pkg::MCAUSE_RESET;
            mtval_r    <= csr_pkg::WORD_RESET;
        end else if (csr_write_enable_i) begin
            case (csr_write_addr_i)
                csr_pkg::CSR_MTVEC:    mtvec_r    <= csr_pkg::mtvec_t'(csr_write_data_i);
                csr_pkg::CSR_MSCRATCH: mscratch_r <= csr_write_data_i;
                csr_pkg::CSR_MEPC:     mepc_r     <= csr_write_data_i;
                csr_pkg::CSR_MCAUSE:   mcause_r   <= csr_pkg::mcause_t'(csr_write_data_i);
                csr_pkg::CSR_MTVAL:    mtval_r    <= csr_write_data_i;
                default: ;                             // Handled elsewhere or ignored
            endcase
        end
    end

    // Rebuild mstatus with every other field zero
    always_comb begin
        mstatus_o      = '0;
        mstatus_o.mie  = mie_r;
        mstatus_o.mpie = mpie_r;
    end

    assign mtvec_o    = mtvec_r;
    assign mscratch_o = mscratch_r;
    assign mepc_o     = mepc_r;
    assign mcause_o   = mcause_r;
    assign mtval_o    = mtval_r;

endmodule

// ==== csr_read_mux.sv ====
`timescale 1ns/1ps

module csr_read_mux (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                csr_read_enable_i,
    input  csr_pkg::csr_addr_t  csr_read_addr_i,
    input  csr_pkg::dword_t     mcycle_i,
    input  csr_pkg::dword_t     minstret_i,
    input  csr_pkg::dword_t     time_i,
    input  csr_pkg::word_t      mcountinhibit_i,
    input  csr_pkg::mstatus_t   mstatus_i,
    input  csr_pkg::mtvec_t     mtvec_i,
    input  csr_pkg::word_t      mscratch_i,
    input  csr_pkg::word_t      mepc_i,
    input  csr_pkg::mcause_t    mcause_i,
    input  csr_pkg::word_t      mtval_i,
    output csr_pkg::word_t      csr_read_data_o
);

    csr_pkg::word_t read_sel;   // Addressed value, before the register
    csr_pkg::word_t read_data_r;

    always_comb begin
        case (csr_read_addr_i)
            // Identity registers
            csr_pkg::CSR_MISA:      read_sel = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MVENDORID: read_sel = '0;   // Non-commercial
            csr_pkg::CSR_MARCHID:   read_sel = '0;   // No assigned ID
            csr_pkg::CSR_MIMPID:    read_sel = csr_pkg::MIMPID_VALUE;
            csr_pkg::CSR_MHARTID:   read_sel = '0;   // Single hart

            // Trap bank
            csr_pkg::CSR_MSTATUS:   read_sel = csr_pkg::word_t'(mstatus_i);
            csr_pkg::CSR_MTVEC:     read_sel = csr_pkg::word_t'(mtvec_i);
            csr_pkg::CSR_MSCRATCH:  read_sel = mscratch_i;
            csr_pkg::CSR_MEPC:      read_sel = mepc_i;
            csr_pkg::CSR_MCAUSE:    read_sel = csr_pkg::word_t'(mcause_i);
            csr_pkg::CSR_MTVAL:     read_sel = mtval_i;

            // Counter bank
            csr_pkg::CSR_MCOUNTINHIBIT: read_sel = mcountinhibit_i;
            csr_pkg::CSR_MCYCLE,
            csr_pkg::CSR_CYCLE:     read_sel = mcycle_i[31:0];
            csr_pkg::CSR_MCYCLEH,
            csr_pkg::CSR_CYCLEH:    read_sel = mcycle_i[63:32];
            csr_pkg::CSR_MINSTRET,
            csr_pkg::CSR_INSTRET:   read_sel = minstret_i[31:0];
            csr_pkg::CSR_MINSTRETH,
            csr_pkg::CSR_INSTRETH:  read_sel = minstret_i[63:32];
            csr_pkg::CSR_TIME:      read_sel = time_i[31:0];
            csr_pkg::CSR_TIMEH:     read_sel = time_i[63:32];

            default:                read_sel = '0;   // Unknown or dropped
        endcase
    end

    // Output holds data only in the cycle after a read strobe
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            read_data_r <= csr_pkg::WORD_RESET;
        end else if (csr_read_enable_i) begin
            read_data_r <= read_sel;
        end else begin
            read_data_r <= '0;
        end
    end

    assign csr_read_data_o = read_data_r;

endmodule

// ==== cpu_csr.sv ====
`timescale 1ns/1ps

module cpu_csr (
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                retired_i,           // Instruction retired
    input  logic                mtrap_i,             // Trap taken
    input  logic                mret_i,              // Return from trap
    input  csr_pkg::csr_addr_t  csr_read_addr_i,
    input  logic                csr_read_enable_i,
    output csr_pkg::word_t      csr_read_data_o,
    input  csr_pkg::csr_addr_t  csr_write_addr_i,
    input  csr_pkg::word_t      csr_write_data_i,
    input  logic                csr_write_enable_i
);

    // Counter bank state
    csr_pkg::dword_t   mcycle;
    csr_pkg::dword_t   minstret;
    csr_pkg::dword_t   time_cnt;
    csr_pkg::word_t    mcountinhibit;

    // Trap bank state
    csr_pkg::mstatus_t mstatus;
    csr_pkg::mtvec_t   mtvec;
    csr_pkg::word_t    mscratch;
    csr_pkg::word_t    mepc;
    csr_pkg::mcause_t  mcause;
    csr_pkg::word_t    mtval;

    // Both banks see every write, each picks its own addresses
    csr_counter_bank u_counter_bank (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .retired_i          (retired_i),
        .csr_write_enable_i (csr_write_enable_i),
        .csr_write_addr_i   (csr_write_addr_i),
        .csr_write_data_i   (csr_write_data_i),
        .mcycle_o           (mcycle),
        .minstret_o         (minstret),
        .time_o             (time_cnt),
        .mcountinhibit_o    (mcountinhibit)
    );

    csr_trap_regs u_trap_regs (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .mtrap_i            (mtrap_i),
        .mret_i             (mret_i),
        .csr_write_enable_i (csr_write_enable_i),
        .csr_write_addr_i   (csr_write_addr_i),
        .csr_write_data_i   (csr_write_data_i),
        .mstatus_o          (mstatus),
        .mtvec_o            (mtvec),
        .mscratch_o         (mscratch),
        .mepc_o             (mepc),
        .mtval_o            (mtval),
        .mcause_o           (mcause)
    );

    csr_read_mux u_read_mux (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .csr_read_enable_i  (csr_read_enable_i),
        .csr_read_addr_i    (csr_read_addr_i),
        .mcycle_i           (mcycle),
        .minstret_i         (minstret),
        .time_i             (time_cnt),
        .mcountinhibit_i    (mcountinhibit),
        .mstatus_i          (mstatus),
        .mtvec_i            (mtvec),
        .mscratch_i         (mscratch),
        .mepc_i             (mepc),
        .mcause_i           (mcause),
        .mtval_i            (mtval),
        .csr_read_data_o    (csr_read_data_o)
    );

endmodule

// ==== cpu_csr_assert.sv ====
`timescale 1ns/1ps

module cpu_csr_assert (
    input logic                clk_i,
    input logic                reset_i,
    input logic                retired_i,
    input logic                mtrap_i,
    input logic                mret_i,
    input csr_pkg::csr_addr_t  csr_read_addr_i,
    input logic                csr_read_enable_i,
    input csr_pkg::word_t      csr_read_data_o,
    input csr_pkg::csr_addr_t  csr_write_addr_i,
    input csr_pkg::word_t      csr_write_data_i,
    input logic                csr_write_enable_i
);

    int fail_count = 0;  // Failed assertions so far

    // Shadow of the writable state
    csr_pkg::word_t mtvec_s, mscratch_s, mepc_s, mcause_s, mtval_s, inhib_s;
    logic           mie_s, mpie_s;

    // Counter model indexed by counter_sel
    csr_pkg::word_t acc [4];        // Expected steps so far
    csr_pkg::word_t inc [4];        // Step at this edge
    csr_pkg::word_t base_data [4];  // Last known low half
    csr_pkg::word_t base_acc [4];
    logic           base_ok [4];

    // r1 holds the read whose data is on the port now
    logic           r1_rst, r1_en, r1_fix, r1_hi, r2_hi;
    logic [1:0]     r1_sel, r1_wsel, rsel, wsel;
    csr_pkg::word_t r1_exp, r1_acc, r1_wdata, r1_wacc, prev_data;
    csr_pkg::word_t exp_now, cnt_got, cnt_exp;
    logic           fix_now;

    function automatic logic [1:0] counter_sel(input csr_pkg::csr_addr_t a);
        case (a)
            csr_pkg::CSR_MCYCLE, csr_pkg::CSR_CYCLE:     return 2'd1;
            csr_pkg::CSR_MINSTRET, csr_pkg::CSR_INSTRET: return 2'd2;
            csr_pkg::CSR_TIME:                           return 2'd3;
            default:                                     return 2'd0;
        endcase
    endfunction

    always_comb begin
        inc[0]  = '0;
        inc[1]  = {31'b0, ~inhib_s[csr_pkg::MCOUNTINHIBIT_CY]};
        inc[2]  = {31'b0, retired_i & ~inhib_s[csr_pkg::MCOUNTINHIBIT_IR]};
        inc[3]  = 32'd1;                                 // Time never stops
        rsel    = counter_sel(csr_read_addr_i);
        wsel    = csr_write_enable_i ? counter_sel(csr_write_addr_i) : 2'd0;
        fix_now = 1'b1;
        exp_now = '0;                                    // Unknown reads zero
        case (csr_read_addr_i)
            csr_pkg::CSR_MISA:          exp_now = csr_pkg::MISA_VALUE;
            csr_pkg::CSR_MIMPID:        exp_now = csr_pkg::MIMPID_VALUE;
            csr_pkg::CSR_MSTATUS:       exp_now = {24'b0, mpie_s, 3'b0, mie_s, 3'b0};
            csr_pkg::CSR_MTVEC:         exp_now = mtvec_s;
            csr_pkg::CSR_MSCRATCH:      exp_now = mscratch_s;
            csr_pkg::CSR_MEPC:          exp_now = mepc_s;
            csr_pkg::CSR_MCAUSE:        exp_now = mcause_s;
            csr_pkg::CSR_MTVAL:         exp_now = mtval_s;
            csr_pkg::CSR_MCOUNTINHIBIT: exp_now = inhib_s;
            csr_pkg::CSR_MCYCLE, csr_pkg::CSR_MCYCLEH, csr_pkg::CSR_MINSTRET,
            csr_pkg::CSR_MINSTRETH, csr_pkg::CSR_CYCLE, csr_pkg::CSR_CYCLEH,
            csr_pkg::CSR_INSTRET, csr_pkg::CSR_INSTRETH, csr_pkg::CSR_TIME,
            csr_pkg::CSR_TIMEH:         fix_now = 1'b0;  // Counters checked by step
            default: ;
        endcase
        cnt_got = csr_read_data_o - base_data[r1_sel];
        cnt_exp = r1_acc - base_acc[r1_sel];
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            {mtvec_s, mscratch_s, mepc_s, mcause_s, mtval_s, inhib_s} <= '0;
            {mie_s, mpie_s} <= 2'b00;
            for (int i = 0; i < 4; i++) begin
                acc[i]     <= '0;
                base_ok[i] <= 1'b0;
            end
            {r1_en, r1_fix, r1_hi, r2_hi, r1_sel, r1_wsel} <= '0;
            r1_rst <= 1'b1;                               // Port must read zero next
        end else begin
            r1_rst    <= 1'b0;
            r1_en     <= csr_read_enable_i;
            r1_fix    <= csr_read_enable_i && fix_now;
            r1_exp    <= exp_now;
            r1_sel    <= csr_read_enable_i ? rsel : 2'd0;
            r1_acc    <= acc[rsel];                       // State before this edge
            r1_hi     <= csr_read_enable_i && (csr_read_addr_i == csr_pkg::CSR_MINSTRETH ||
                                               csr_read_addr_i == csr_pkg::CSR_INSTRETH);
            r2_hi     <= r1_hi;
            prev_data <= csr_read_data_o;
            r1_wsel   <= wsel;
            r1_wdata  <= csr_write_data_i + inc[wsel];    // Written half keeps counting
            r1_wacc   <= acc[wsel] + inc[wsel];
            for (int i = 1; i < 4; i++) begin
                acc[i] <= acc[i] + inc[i];
            end
            if (r1_sel != 2'd0) begin
                base_data[r1_sel] <= csr_read_data_o;
                base_acc[r1_sel]  <= r1_acc;
                base_ok[r1_sel]   <= 1'b1;
            end
            if (r1_wsel != 2'd0) begin                    // Load is newer than the read
                base_data[r1_wsel] <= r1_wdata;
                base_acc[r1_wsel]  <= r1_wacc;
                base_ok[r1_wsel]   <= 1'b1;
            end
            if (csr_write_enable_i) begin
                case (csr_write_addr_i)
                    csr_pkg::CSR_MTVEC:         mtvec_s    <= csr_write_data_i;
                    csr_pkg::CSR_MSCRATCH:      mscratch_s <= csr_write_data_i;
                    csr_pkg::CSR_MEPC:          mepc_s     <= csr_write_data_i;
                    csr_pkg::CSR_MCAUSE:        mcause_s   <= csr_write_data_i;
                    csr_pkg::CSR_MTVAL:         mtval_s    <= csr_write_data_i;
                    csr_pkg::CSR_MCOUNTINHIBIT: inhib_s    <= csr_write_data_i;
                    default: ;
                endcase
            end
            // Software write beats trap and return
            if (csr_write_enable_i && csr_write_addr_i == csr_pkg::CSR_MSTATUS) begin
                mie_s  <= csr_write_data_i[3];
                mpie_s <= csr_write_data_i[7];
            end else if (mtrap_i) begin
                mie_s  <= 1'b0;
                mpie_s <= mie_s;
            end else if (mret_i) begin
                mie_s  <= mpie_s;
                mpie_s <= 1'b1;
            end
        end
    end

    a_idle_zero: assert property (@(posedge clk_i) disable iff (reset_i)
        (r1_rst || !r1_en) |-> csr_read_data_o == '0)
        else begin
            fail_count++;
            $error("error csr_read_data_o %h expected 00000000", $sampled(csr_read_data_o));
        end

    a_fixed_value: assert property (@(posedge clk_i) disable iff (reset_i)
        r1_fix |-> csr_read_data_o == r1_exp)
        else begin
            fail_count++;
            $error("error csr_read_data_o %h expected %h", $sampled(csr_read_data_o),
                   $sampled(r1_exp));
        end

    a_counter_step: assert property (@(posedge clk_i) disable iff (reset_i)
        (r1_sel != 2'd0 && base_ok[r1_sel]) |-> cnt_got == cnt_exp)
        else begin
            fail_count++;
            $error("error csr_read_data_o step %h expected %h", $sampled(cnt_got),
                   $sampled(cnt_exp));
        end

    a_instreth_alias: assert property (@(posedge clk_i) disable iff (reset_i)
        (r1_hi && r2_hi) |-> csr_read_data_o == prev_data)
        else begin
            fail_count++;
            $error("error csr_read_data_o %h expected %h", $sampled(csr_read_data_o),
                   $sampled(prev_data));
        end

endmodule

bind cpu_csr cpu_csr_assert u_csr_assert (.*);

// ==== tb_cpu_csr.sv ====
`timescale 1ns/1ps

module tb_cpu_csr;

    logic               clk_i;
    logic               reset_i;
    logic               retired_i, mtrap_i, mret_i;
    logic               csr_read_enable_i, csr_write_enable_i;
    csr_pkg::csr_addr_t csr_read_addr_i, csr_write_addr_i;
    csr_pkg::word_t     csr_read_data_o, csr_write_data_i;
    int                 cycles = 0;

    csr_pkg::csr_addr_t id_addr [5] = '{csr_pkg::CSR_MISA, csr_pkg::CSR_MVENDORID,
        csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID};
    csr_pkg::csr_addr_t plain_addr [5] = '{csr_pkg::CSR_MTVEC, csr_pkg::CSR_MSCRATCH,
        csr_pkg::CSR_MEPC, csr_pkg::CSR_MCAUSE, csr_pkg::CSR_MTVAL};

    cpu_csr i_cpu_csr (.*);

    always #4 clk_i = ~clk_i;

    // Stops the run on a timeout or the first assertion failure
    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (i_cpu_csr.u_csr_assert.fail_count != 0) begin
            $display("=== FAIL ===");
            $fatal(1, "assertion failed at cycle %0d", cycles);
        end else if (cycles >= 2000) begin
            $display("=== FAIL ===");
            $fatal(1, "run did not finish within 2000 cycles");
        end
    end

    // One cycle of strobes applied at the falling edge
    task automatic step(input logic re, input csr_pkg::csr_addr_t ra, input logic we,
                        input csr_pkg::csr_addr_t wa, input csr_pkg::word_t wd);
        csr_read_enable_i  = re;
        csr_read_addr_i    = ra;
        csr_write_enable_i = we;
        csr_write_addr_i   = wa;
        csr_write_data_i   = wd;
        @(negedge clk_i);
        {csr_read_enable_i, csr_write_enable_i, retired_i, mtrap_i, mret_i} = '0;
    endtask

    task automatic read_csr(input csr_pkg::csr_addr_t a);
        step(1'b1, a, 1'b0, '0, '0);
    endtask

    task automatic write_csr(input csr_pkg::csr_addr_t a, input csr_pkg::word_t d);
        step(1'b0, '0, 1'b1, a, d);
    endtask

    initial begin
        csr_pkg::csr_addr_t a;
        void'($urandom(32'hfeab74cd));
        clk_i = 1'b0;
        reset_i = 1'b1;
        {retired_i, mtrap_i, mret_i, csr_read_enable_i, csr_write_enable_i} = '0;
        {csr_read_addr_i, csr_write_addr_i, csr_write_data_i} = '0;
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;

        // Idle port and dropped addresses
        step(1'b0, '0, 1'b0, '0, '0);
        read_csr(12'h3A0);
        read_csr(12'h344);
        read_csr(12'h7FF);
        step(1'b0, '0, 1'b0, '0, '0);

        // Identity registers ignore writes
        for (int i = 0; i < 5; i++) begin
            read_csr(id_addr[i]);
            write_csr(id_addr[i], $urandom);
            read_csr(id_addr[i]);
        end

        // Plain registers and read during write
        repeat (60) begin
            a = plain_addr[$urandom_range(4, 0)];
            write_csr(a, $urandom);
            read_csr(a);
            step(1'b1, a, 1'b1, a, $urandom);
            read_csr(a);
        end

        // Cycle and time with and without inhibit
        repeat (10) read_csr(csr_pkg::CSR_CYCLE);
        repeat (10) read_csr(csr_pkg::CSR_TIME);
        write_csr(csr_pkg::CSR_MCOUNTINHIBIT, 32'h1);
        repeat (8) read_csr(csr_pkg::CSR_CYCLE);
        repeat (4) read_csr(csr_pkg::CSR_TIME);
        write_csr(csr_pkg::CSR_MCOUNTINHIBIT, 32'h0);
        repeat (10) begin
            write_csr(csr_pkg::CSR_CYCLE, $urandom);
            read_csr(csr_pkg::CSR_CYCLE);
            read_csr(csr_pkg::CSR_MCYCLE);
        end

        // Retired instructions with sparse reads
        for (int k = 0; k < 100; k++) begin
            if (k == 80) write_csr(csr_pkg::CSR_MCOUNTINHIBIT, 32'h4);
            retired_i = $urandom_range(1, 0);
            if ($urandom_range(2, 0) == 0) read_csr(csr_pkg::CSR_INSTRET);
            else step(1'b0, '0, 1'b0, '0, '0);
        end
        write_csr(csr_pkg::CSR_MCOUNTINHIBIT, 32'h0);
        write_csr(csr_pkg::CSR_MINSTRETH, $urandom);  // Nonzero high half for the alias
        repeat (10) begin
            read_csr(csr_pkg::CSR_MINSTRETH);
            read_csr(csr_pkg::CSR_INSTRETH);
        end

        // Trap entry and return on the enable stack
        repeat (20) begin
            write_csr(csr_pkg::CSR_MSTATUS, $urandom & 32'h88);
            read_csr(csr_pkg::CSR_MSTATUS);
            mtrap_i = 1'b1;
            read_csr(csr_pkg::CSR_MSTATUS);
            mret_i = 1'b1;
            read_csr(csr_pkg::CSR_MSTATUS);
            read_csr(csr_pkg::CSR_MSTATUS);       // State after the return
            mtrap_i = 1'b1;                       // Loses to the write
            step(1'b0, '0, 1'b1, csr_pkg::CSR_MSTATUS, $urandom);
            read_csr(csr_pkg::CSR_MSTATUS);
        end

        repeat (3) @(negedge clk_i);
        if (i_cpu_csr.u_csr_assert.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("=== FAIL ===");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

// ==== flist.f ====
csr_pkg.sv
csr_counter.sv
csr_counter_bank.sv
csr_trap_regs.sv
csr_read_mux.sv
cpu_csr.sv
cpu_csr_assert.sv
tb_cpu_csr.sv

// ==== Bender.yml ====
package:
  name: cpu_csr

sources:
  - csr_pkg.sv
  - csr_counter.sv
  - csr_counter_bank.sv
  - csr_trap_regs.sv
  - csr_read_mux.sv
  - cpu_csr.sv
  - target: test
    files:
      - cpu_csr_assert.sv
      - tb_cpu_csr.sv
